// File: drac_pkg.sv
// Core-wide types seen by the fetch stage.
// Address, instruction word and fetch exception cause.

`default_nettype none

`include "icache_params.svh"

package drac_pkg;

    // Virtual address of a fetch
    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

    // One instruction word
    typedef logic [`ICACHE_WORD_W-1:0] inst_t;

    // Fetch exception cause
    // Values follow the RISC-V mcause codes
    // NONE uses a code the fetch side never reports
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        NONE                  = 4'd15
    } exc_cause_t;

endpackage

`default_nettype wire

// File: fetch_exception_unit.sv
// Fetch exception detection for the cache interface.
// Flags misaligned fetches and TLB faults, purely combinational.

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module fetch_exception_unit (
    input  logic                 fetch_req_valid_i,
    input  drac_pkg::addr_t      fetch_vaddr_i,
    input  logic                 tlb_resp_xcpt_i,
    output logic                 misaligned_o,
    output logic                 exc_valid_o,
    output drac_pkg::exc_cause_t exc_cause_o,
    output drac_pkg::addr_t      exc_origin_o
);

    import drac_pkg::*;

    logic tlb_fault;

    // Instructions are word aligned here
    // Any of the two low bits set is a misaligned fetch
    assign misaligned_o = fetch_req_valid_i & (fetch_vaddr_i[1] | fetch_vaddr_i[0]);

    // TLB fault only counts for a live request
    assign tlb_fault = fetch_req_valid_i & tlb_resp_xcpt_i;

    assign exc_valid_o = misaligned_o | tlb_fault;

    // Misalignment wins over the TLB fault
    assign exc_cause_o = misaligned_o ? INSTR_ADDR_MISALIGNED :
                         tlb_fault    ? INSTR_ACCESS_FAULT    :
                                        NONE;

    // Origin is the faulting fetch address
    assign exc_origin_o = fetch_vaddr_i;

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
drac_pkg.sv
icache_pkg.sv
fetch_exception_unit.sv
icache_line_buffer.sv
icache_ctrl.sv
icache_interface_top.sv
icache_interface_chk.sv
tb_icache_interface.sv

// File: icache_ctrl.sv
// Control FSM of the fetch-side cache interface.
// Issues cache requests on buffer misses, waits for the line and
// raises fetch-valid on hits and on response acceptance.

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_ctrl (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic fetch_req_valid_i,
    input  logic buffer_miss_i,
    input  logic misaligned_i,
    input  logic tlb_resp_xcpt_i,
    input  logic icache_resp_valid_i,
    output logic icache_req_valid_o,
    output logic icache_resp_ready_o,
    output logic resp_accept_o,
    output logic fetch_resp_valid_o
);

    import icache_pkg::*;

    icache_state_t state_q;
    icache_state_t state_d;
    logic          req_ok;
    logic          access_need;
    logic          buffer_hit;

    // Valid request without exception
    assign req_ok = fetch_req_valid_i & !misaligned_i & !tlb_resp_xcpt_i;

    // Cache access only on a clean request that misses the buffer
    assign access_need = req_ok & buffer_miss_i;
    assign buffer_hit  = req_ok & !buffer_miss_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= RESET_ST;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d             = state_q;
        icache_req_valid_o  = 1'b0;
        icache_resp_ready_o = 1'b0;
        resp_accept_o       = 1'b0;
        fetch_resp_valid_o  = 1'b0;
        case (state_q)
            RESET_ST: begin
                state_d = NO_REQ;
            end
            NO_REQ, RESP_READY: begin
                // One-cycle request pulse on a miss
                icache_req_valid_o = access_need;
                fetch_resp_valid_o = buffer_hit;
                state_d            = access_need ? REQ_VALID : NO_REQ;
            end
            REQ_VALID: begin
                // Wait for the line
                icache_resp_ready_o = 1'b1;
                resp_accept_o       = icache_resp_valid_i;
                fetch_resp_valid_o  = icache_resp_valid_i & !tlb_resp_xcpt_i;
                state_d             = icache_resp_valid_i ? RESP_READY : REQ_VALID;
            end
            default: begin
                state_d = RESET_ST;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: icache_interface_chk.sv
// Concurrent assertions on the cache handshake and the reset state.
// Bound to the interface top level; the testbench reads fail_cnt.

`timescale 1ns/1ps
`default_nettype none

module icache_interface_chk (
    input logic clk_i,
    input logic rstn_i,
    input logic icache_req_valid_o,
    input logic icache_resp_ready_o,
    input logic icache_resp_valid_i,
    input logic tlb_req_valid_o,
    input logic fetch_resp_valid_o,
    input logic fetch_exc_valid_o
);

    int   fail_cnt = 0;
    logic pending_q;

    // Set by the request pulse, cleared by the accepted response
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q <= 1'b0;
        end else if (icache_req_valid_o) begin
            pending_q <= 1'b1;
        end else if (icache_resp_valid_i & icache_resp_ready_o) begin
            pending_q <= 1'b0;
        end
    end

    a_single_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        icache_req_valid_o |=> !icache_req_valid_o)
        else begin
            fail_cnt++;
            $error("cache request high in two consecutive cycles");
        end

    a_ready_pending: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !pending_q |-> !icache_resp_ready_o)
        else begin
            fail_cnt++;
            $error("response ready with no request pending");
        end

    a_reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |-> !(icache_req_valid_o | icache_resp_ready_o | tlb_req_valid_o |
                      fetch_resp_valid_o | fetch_exc_valid_o))
        else begin
            fail_cnt++;
            $error("control output high during reset");
        end

endmodule

bind icache_interface_top icache_interface_chk chk (
    .clk_i               (clk_i),
    .rstn_i              (rstn_i),
    .icache_req_valid_o  (icache_req_valid_o),
    .icache_resp_ready_o (icache_resp_ready_o),
    .icache_resp_valid_i (icache_resp_valid_i),
    .tlb_req_valid_o     (tlb_req_valid_o),
    .fetch_resp_valid_o  (fetch_resp_valid_o),
    .fetch_exc_valid_o   (fetch_exc_valid_o)
);

`default_nettype wire

// File: icache_interface_top.sv
// Top of the fetch to instruction cache interface.
// Connects the control FSM, the line buffer and the exception unit
// to the fetch stage, the cache and the TLB.

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_interface_top (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     fetch_req_valid_i,
    input  drac_pkg::addr_t          fetch_vaddr_i,
    input  logic                     tlb_resp_xcpt_i,
    input  logic                     icache_resp_valid_i,
    input  icache_pkg::icache_line_t icache_resp_line_i,
    input  logic                     ptw_invalidate_i,
    output logic                     icache_req_valid_o,
    output icache_pkg::icache_idx_t  icache_req_idx_o,
    output logic                     icache_resp_ready_o,
    output logic                     tlb_req_valid_o,
    output icache_pkg::icache_vpn_t  tlb_req_vpn_o,
    output logic                     fetch_resp_valid_o,
    output drac_pkg::inst_t          fetch_data_o,
    output logic                     fetch_exc_valid_o,
    output drac_pkg::exc_cause_t     fetch_exc_cause_o,
    output drac_pkg::addr_t          fetch_exc_origin_o
);

    logic misaligned;
    logic buffer_miss;
    logic resp_accept;
    logic req_valid;

    // Page offset to the cache, page number to the TLB
    assign icache_req_idx_o = fetch_vaddr_i[`ICACHE_IDX_W-1:0];
    assign tlb_req_vpn_o    = fetch_vaddr_i[`ICACHE_ADDR_W-1:`ICACHE_IDX_W];

    // TLB lookup goes out with every cache request
    assign icache_req_valid_o = req_valid;
    assign tlb_req_valid_o    = req_valid;

    icache_ctrl u_ctrl (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .fetch_req_valid_i   (fetch_req_valid_i),
        .buffer_miss_i       (buffer_miss),
        .misaligned_i        (misaligned),
        .tlb_resp_xcpt_i     (tlb_resp_xcpt_i),
        .icache_resp_valid_i (icache_resp_valid_i),
        .icache_req_valid_o  (req_valid),
        .icache_resp_ready_o (icache_resp_ready_o),
        .resp_accept_o       (resp_accept),
        .fetch_resp_valid_o  (fetch_resp_valid_o)
    );

    // PTW invalidate flushes the buffered line
    icache_line_buffer u_line_buffer (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .fetch_req_valid_i  (fetch_req_valid_i),
        .fetch_vaddr_i      (fetch_vaddr_i),
        .resp_accept_i      (resp_accept),
        .icache_resp_line_i (icache_resp_line_i),
        .invalidate_i       (ptw_invalidate_i),
        .buffer_miss_o      (buffer_miss),
        .fetch_data_o       (fetch_data_o)
    );

    fetch_exception_unit u_exc (
        .fetch_req_valid_i (fetch_req_valid_i),
        .fetch_vaddr_i     (fetch_vaddr_i),
        .tlb_resp_xcpt_i   (tlb_resp_xcpt_i),
        .misaligned_o      (misaligned),
        .exc_valid_o       (fetch_exc_valid_o),
        .exc_cause_o       (fetch_exc_cause_o),
        .exc_origin_o      (fetch_exc_origin_o)
    );

endmodule

`default_nettype wire

// File: icache_line_buffer.sv
// One-line buffer in front of the instruction cache.
// Keeps the last accepted line with its tag, reports hit or miss
// and selects the addressed instruction word.

`timescale 1ns/1ps
`default_nettype none

`include "icache_params.svh"

module icache_line_buffer (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   fetch_req_valid_i,
    input  drac_pkg::addr_t        fetch_vaddr_i,
    input  logic                   resp_accept_i,
    input  icache_pkg::icache_line_t icache_resp_line_i,
    input  logic                   invalidate_i,
    output logic                   buffer_miss_o,
    output drac_pkg::inst_t        fetch_data_o
);

    import icache_pkg::*;

    icache_line_t line_q;
    icache_line_t line_sel;
    line_tag_t    tag_q;
    line_tag_t    req_tag;
    logic         valid_q;
    logic         load;
    logic [1:0]   word_sel;

    // Tag of the current request
    assign req_tag = fetch_vaddr_i[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W];

    // Load the line on the accepting edge
    assign load = resp_accept_i & fetch_req_valid_i;

    // Valid bit
    // Invalidate beats a load in the same cycle
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (invalidate_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end
    end

    // Line and tag payload
    always_ff @(posedge clk_i) begin
        if (load) begin
            line_q <= icache_resp_line_i;
            tag_q  <= req_tag;
        end
    end

    // Miss on empty buffer or other line
    assign buffer_miss_o = !valid_q | (tag_q != req_tag);

    // In the accept cycle the word comes straight from the cache
    assign line_sel = resp_accept_i ? icache_resp_line_i : line_q;

    // Word inside the line, address bits 3 to 2
    assign word_sel = fetch_vaddr_i[`ICACHE_OFFSET_W-1:2];

    always_comb begin
        case (word_sel)
            2'd0: fetch_data_o = line_sel[0*`ICACHE_WORD_W +: `ICACHE_WORD_W];
            2'd1: fetch_data_o = line_sel[1*`ICACHE_WORD_W +: `ICACHE_WORD_W];
            2'd2: fetch_data_o = line_sel[2*`ICACHE_WORD_W +: `ICACHE_WORD_W];
            default: fetch_data_o = line_sel[3*`ICACHE_WORD_W +: `ICACHE_WORD_W];
        endcase
    end

endmodule

`default_nettype wire

// File: icache_params.svh
// Width definitions shared by the fetch-side cache interface.
// Included by both packages and by every RTL module of the subsystem.

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Virtual fetch address
`define ICACHE_ADDR_W 40

// One cache line holds four instruction words
`define ICACHE_LINE_W 128
`define ICACHE_WORD_W 32

// Page offset sent to the cache as index
`define ICACHE_IDX_W 12

// Virtual page number sent to the TLB
`define ICACHE_VPN_W 28

// Byte offset inside one line
`define ICACHE_OFFSET_W 4

`endif

// File: icache_pkg.sv
// Types of the instruction cache and TLB interface.
// Line, index, page number, buffer tag and controller state.

`default_nettype none

`include "icache_params.svh"

package icache_pkg;

    typedef logic [`ICACHE_LINE_W-1:0] icache_line_t;
    typedef logic [`ICACHE_IDX_W-1:0]  icache_idx_t;
    typedef logic [`ICACHE_VPN_W-1:0]  icache_vpn_t;

    // Address bits above the line offset
    typedef logic [`ICACHE_ADDR_W-`ICACHE_OFFSET_W-1:0] line_tag_t;

    // Controller states
    typedef enum logic [1:0] {
        RESET_ST,
        NO_REQ,
        REQ_VALID,
        RESP_READY
    } icache_state_t;

endpackage

`default_nettype wire

// File: icache_stimulus.txt
# inv addr fault latency line exp_req exp_valid exp_word exp_exc exp_cause (all hex)
# inv pulses ptw_invalidate_i before the fetch, latency is the cache wait in cycles
0 12345678a4 0 3 a3a3a3a3a2a2a2a2a1a1a1a1a0a0a0a0 1 1 a1a1a1a1 0 f
0 12345678a8 0 0 0 0 1 a2a2a2a2 0 f
0 12345678ac 0 0 0 0 1 a3a3a3a3 0 f
0 12345678a0 0 0 0 0 1 a0a0a0a0 0 f
0 0badcafe10 0 5 b3b3b3b3b2b2b2b2b1b1b1b1b0b0b0b0 1 1 b0b0b0b0 0 f
0 0badcafe1c 0 0 0 0 1 b3b3b3b3 0 f
0 0badcafe12 0 0 0 0 0 0 1 0
0 0badcafe14 1 0 0 0 0 0 1 1
1 0badcafe1c 0 2 c3c3c3c3c2c2c2c2c1c1c1c1c0c0c0c0 1 1 c3c3c3c3 0 f
0 0badcafe18 0 0 0 0 1 c2c2c2c2 0 f
0 ffffff0004 1 0 0 0 0 0 1 1
0 ffffff0001 1 0 0 0 0 0 1 0
0 7000000030 0 7 d3d3d3d3d2d2d2d2d1d1d1d1d0d0d0d0 1 1 d0d0d0d0 0 f
0 7000000038 0 0 0 0 1 d2d2d2d2 0 f

// File: tb_icache_interface.sv
// Testbench for the fetch-side instruction cache interface.
// Reads fetches from icache_stimulus.txt, models the cache and TLB
// and checks every response against the expected values of the file.

`timescale 1ns/1ps
`default_nettype none

module tb_icache_interface;

    import drac_pkg::*;
    import icache_pkg::*;

    logic         clk_i = 1'b0;
    logic         rstn_i;
    logic         fetch_req_valid_i;
    addr_t        fetch_vaddr_i;
    logic         tlb_resp_xcpt_i;
    logic         icache_resp_valid_i;
    icache_line_t icache_resp_line_i;
    logic         ptw_invalidate_i;
    logic         icache_req_valid_o;
    icache_idx_t  icache_req_idx_o;
    logic         icache_resp_ready_o;
    logic         tlb_req_valid_o;
    icache_vpn_t  tlb_req_vpn_o;
    logic         fetch_resp_valid_o;
    inst_t        fetch_data_o;
    logic         fetch_exc_valid_o;
    exc_cause_t   fetch_exc_cause_o;
    addr_t        fetch_exc_origin_o;

    // One entry per row of the stimulus file
    logic         t_inv [64];
    addr_t        t_addr [64];
    logic         t_fault [64];
    int           t_lat [64];
    icache_line_t t_line [64];
    logic         t_req [64];
    logic         t_valid [64];
    inst_t        t_word [64];
    logic         t_exc [64];
    logic [3:0]   t_cause [64];

    int n_tests = 0;
    int err_cnt = 0;
    int fail_tests = 0;
    int cycle_cnt = 0;
    int cycle_limit = 1000;

    icache_interface_top dut (.*);

    always #4 clk_i = ~clk_i;

    // Run limit from the stimulus length
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string sig, input logic [63:0] got,
                                   input logic [63:0] exp);
        err_cnt++;
        $display("Fail %s: got %h expected %h", sig, got, exp);
    endtask

    task automatic load_stimulus(output bit ok);
        int    fd;
        int    lat_sum;
        string row;
        ok = 1'b0;
        lat_sum = 0;
        fd = $fopen("icache_stimulus.txt", "r");
        if (fd != 0) begin
            while ($fgets(row, fd)) begin
                // Comment and blank rows are skipped
                if (row.substr(0, 0) != "#" &&
                    $sscanf(row, "%h %h %h %h %h %h %h %h %h %h", t_inv[n_tests],
                            t_addr[n_tests], t_fault[n_tests], t_lat[n_tests],
                            t_line[n_tests], t_req[n_tests], t_valid[n_tests],
                            t_word[n_tests], t_exc[n_tests], t_cause[n_tests]) == 10) begin
                    lat_sum += t_lat[n_tests];
                    n_tests++;
                end
            end
            $fclose(fd);
            cycle_limit = 4 + lat_sum + 8 * n_tests;
            ok = (n_tests > 0);
        end
    endtask

    task automatic run_fetch(input int n);
        int errs_before;
        bit accepted;
        errs_before = err_cnt;
        accepted = 1'b0;
        repeat ($urandom_range(2, 0)) @(posedge clk_i);
        if (t_inv[n]) begin
            @(posedge clk_i);
            ptw_invalidate_i <= 1'b1;
            @(posedge clk_i);
            ptw_invalidate_i <= 1'b0;
        end
        @(posedge clk_i);
        fetch_req_valid_i <= 1'b1;
        fetch_vaddr_i     <= t_addr[n];
        tlb_resp_xcpt_i   <= t_fault[n];
        // Request cycle, sampled mid-cycle
        @(negedge clk_i);
        if (icache_req_valid_o !== t_req[n])
            report_mismatch("icache_req_valid_o", icache_req_valid_o, t_req[n]);
        if (tlb_req_valid_o !== t_req[n])
            report_mismatch("tlb_req_valid_o", tlb_req_valid_o, t_req[n]);
        if (t_req[n] && icache_req_idx_o !== t_addr[n][11:0])
            report_mismatch("icache_req_idx_o", icache_req_idx_o, t_addr[n][11:0]);
        if (t_req[n] && tlb_req_vpn_o !== t_addr[n][39:12])
            report_mismatch("tlb_req_vpn_o", tlb_req_vpn_o, t_addr[n][39:12]);
        if (fetch_resp_valid_o !== (t_valid[n] & !t_req[n]))
            report_mismatch("fetch_resp_valid_o", fetch_resp_valid_o, t_valid[n] & !t_req[n]);
        if (t_valid[n] && !t_req[n] && fetch_data_o !== t_word[n])
            report_mismatch("fetch_data_o", fetch_data_o, t_word[n]);
        if (fetch_exc_valid_o !== t_exc[n])
            report_mismatch("fetch_exc_valid_o", fetch_exc_valid_o, t_exc[n]);
        if (fetch_exc_cause_o !== t_cause[n])
            report_mismatch("fetch_exc_cause_o", fetch_exc_cause_o, t_cause[n]);
        if (t_exc[n] && fetch_exc_origin_o !== t_addr[n])
            report_mismatch("fetch_exc_origin_o", fetch_exc_origin_o, t_addr[n]);
        if (t_req[n]) begin
            // Cache model: wait the latency, then offer the line until taken
            @(posedge clk_i);
            repeat (t_lat[n]) @(posedge clk_i);
            icache_resp_valid_i <= 1'b1;
            icache_resp_line_i  <= t_line[n];
            while (!accepted) begin
                @(negedge clk_i);
                if (icache_resp_ready_o)
                    accepted = 1'b1;
                else
                    @(posedge clk_i);
            end
            if (fetch_resp_valid_o !== t_valid[n])
                report_mismatch("fetch_resp_valid_o", fetch_resp_valid_o, t_valid[n]);
            if (fetch_data_o !== t_word[n])
                report_mismatch("fetch_data_o", fetch_data_o, t_word[n]);
        end
        @(posedge clk_i);
        fetch_req_valid_i   <= 1'b0;
        tlb_resp_xcpt_i     <= 1'b0;
        icache_resp_valid_i <= 1'b0;
        if (err_cnt != errs_before)
            fail_tests++;
        $display("test %0d addr %h %s", n, t_addr[n],
                 (err_cnt == errs_before) ? "passed" : "failed");
    endtask

    initial begin
        bit ok;
        void'($urandom(32'hee639315));
        rstn_i              = 1'b0;
        fetch_req_valid_i   = 1'b0;
        fetch_vaddr_i       = '0;
        tlb_resp_xcpt_i     = 1'b0;
        icache_resp_valid_i = 1'b0;
        icache_resp_line_i  = '0;
        ptw_invalidate_i    = 1'b0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Could not read any fetch from icache_stimulus.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            repeat (4) @(posedge clk_i);
            rstn_i <= 1'b1;
            for (int i = 0; i < n_tests; i++) begin
                run_fetch(i);
            end
            @(posedge clk_i);
            $display("Tests: %0d run, %0d failed, %0d check errors, %0d assertion failures",
                     n_tests, fail_tests, err_cnt, dut.chk.fail_cnt);
            if (err_cnt == 0 && fail_tests == 0 && dut.chk.fail_cnt == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
